//--- verilog/animPkg.sv
package animPkg;

    // pose states of the dog sequencer
    typedef enum logic [3:0] {
        Rest, Walk1, Walk2, Walk3, Walk4,
        Sniff1, Sniff2, Surprised, Jump1, Jump2, Hold
    } dogState;

    // register addresses of the tuning block
    typedef enum logic [3:0] {
        StartX         = 4'd0,
        StartY         = 4'd1,
        StepSize       = 4'd2,
        WalkRounds     = 4'd3,
        SniffRounds    = 4'd4,
        SurprisedTicks = 4'd5,
        JumpTicks      = 4'd6,
        JumpDx         = 4'd7,
        JumpRise       = 4'd8,
        JumpFall       = 4'd9
    } cfgAddr;

    // sprite frame codes
    localparam logic [4:0] frameStand     = 5'd0;
    localparam logic [4:0] frameWalk1     = 5'd1;
    localparam logic [4:0] frameWalk2     = 5'd2;
    localparam logic [4:0] frameWalk3     = 5'd3;
    localparam logic [4:0] frameSniff1    = 5'd4;
    localparam logic [4:0] frameSniff2    = 5'd5;
    localparam logic [4:0] frameSurprised = 5'd6;
    localparam logic [4:0] frameJump1     = 5'd7;
    localparam logic [4:0] frameJump2     = 5'd8;

    // power-up tuning values
    localparam int unsigned defStartX         = 11;
    localparam int unsigned defStartY         = 318;
    localparam int unsigned defStepSize       = 4;
    localparam int unsigned defWalkRounds     = 4;
    localparam int unsigned defSniffRounds    = 3;
    localparam int unsigned defSurprisedTicks = 2;
    localparam int unsigned defJumpTicks      = 5;
    localparam int unsigned defJumpDx         = 8;
    localparam int unsigned defJumpRise       = 6;
    localparam int unsigned defJumpFall       = 6;

endpackage

//--- verilog/dogCfgIf.sv
`timescale 1ns/100ps

interface dogCfgIf #(
    parameter int coordWidth = 10
) ();

    // coordinate and displacement values
    logic [coordWidth-1:0] startX;
    logic [coordWidth-1:0] startY;
    logic [coordWidth-1:0] stepSize;
    logic [coordWidth-1:0] jumpDx;
    logic [coordWidth-1:0] jumpRise;
    logic [coordWidth-1:0] jumpFall;

    // phase lengths, never zero
    logic [3:0] walkRounds;
    logic [3:0] sniffRounds;
    logic [3:0] surprisedTicks;
    logic [3:0] jumpTicks;

    modport regs (
        output startX, startY, stepSize, jumpDx, jumpRise, jumpFall,
        output walkRounds, sniffRounds, surprisedTicks, jumpTicks
    );

    modport seq (
        input walkRounds, sniffRounds, surprisedTicks, jumpTicks
    );

    modport move (
        input startX, startY, stepSize, jumpDx, jumpRise, jumpFall
    );

endinterface

//--- verilog/dogConfig.sv
`timescale 1ns/100ps

module dogConfig #(
    parameter int coordWidth = 10
) (
    input  logic                  ANIM_Clk,
    input  logic                  rst,
    input  logic                  cfgWrite,
    input  animPkg::cfgAddr       cfgAddr,
    input  logic [coordWidth-1:0] cfgData,
    dogCfgIf.regs                 cfg
);

    import animPkg::*;

    logic [3:0] countData;

    // a zero count is raised to one so no phase is skipped
    assign countData = (cfgData[3:0] == 4'd0) ? 4'd1 : cfgData[3:0];

    always_ff @(posedge ANIM_Clk)
    begin
        if (rst)
        begin
            cfg.startX         <= coordWidth'(defStartX);
            cfg.startY         <= coordWidth'(defStartY);
            cfg.stepSize       <= coordWidth'(defStepSize);
            cfg.jumpDx         <= coordWidth'(defJumpDx);
            cfg.jumpRise       <= coordWidth'(defJumpRise);
            cfg.jumpFall       <= coordWidth'(defJumpFall);
            cfg.walkRounds     <= 4'(defWalkRounds);
            cfg.sniffRounds    <= 4'(defSniffRounds);
            cfg.surprisedTicks <= 4'(defSurprisedTicks);
            cfg.jumpTicks      <= 4'(defJumpTicks);
        end
        else if (cfgWrite)
        begin
            case (cfgAddr)
                StartX:         cfg.startX         <= cfgData;
                StartY:         cfg.startY         <= cfgData;
                StepSize:       cfg.stepSize       <= cfgData;
                JumpDx:         cfg.jumpDx         <= cfgData;
                JumpRise:       cfg.jumpRise       <= cfgData;
                JumpFall:       cfg.jumpFall       <= cfgData;
                // counts use only the low nibble
                WalkRounds:     cfg.walkRounds     <= countData;
                SniffRounds:    cfg.sniffRounds    <= countData;
                SurprisedTicks: cfg.surprisedTicks <= countData;
                JumpTicks:      cfg.jumpTicks      <= countData;
                default:        ;
            endcase
        end
    end

endmodule

//--- verilog/dogSequencer.sv
`timescale 1ns/100ps

module dogSequencer (
    input  logic             ANIM_Clk,
    input  logic             rst,
    input  logic             go,
    input  logic             scare,
    dogCfgIf.seq             cfg,
    output animPkg::dogState state,
    output logic [4:0]       frame,
    output logic             done
);

    import animPkg::*;

    dogState    nextState;
    // rounds of walking or sniffing finished so far
    logic [3:0] roundCnt;
    // cycles spent in the current dwell pose
    logic [3:0] dwellCnt;
    logic       roundDone;
    logic       dwellDone;

    // last round or last dwell cycle of the current phase
    always_comb
    begin
        roundDone = 1'b0;
        dwellDone = 1'b0;
        case (state)
            Walk4:        roundDone = (roundCnt >= cfg.walkRounds - 4'd1);
            Sniff2:       roundDone = (roundCnt >= cfg.sniffRounds - 4'd1);
            Surprised:    dwellDone = (dwellCnt >= cfg.surprisedTicks - 4'd1);
            Jump1, Jump2: dwellDone = (dwellCnt >= cfg.jumpTicks - 4'd1);
            default:      ;
        endcase
    end

    always_comb
    begin
        nextState = state;
        case (state)
            Rest:      if (go) nextState = Walk1;
            Walk1:     nextState = Walk2;
            Walk2:     nextState = Walk3;
            Walk3:     nextState = Walk4;
            Walk4:
                if (roundDone)
                    nextState = Sniff1;
                else
                    nextState = Walk1;
            Sniff1:    nextState = Sniff2;
            Sniff2:
                if (!roundDone)
                    nextState = Sniff1;
                else if (scare)
                    nextState = Surprised;
                else
                    nextState = Walk1;
            Surprised: if (dwellDone) nextState = Jump1;
            Jump1:     if (dwellDone) nextState = Jump2;
            Jump2:     if (dwellDone) nextState = Hold;
            Hold:      if (go) nextState = Rest;
            default:   nextState = Rest;
        endcase
    end

    always_ff @(posedge ANIM_Clk)
    begin
        if (rst)
        begin
            state    <= Rest;
            roundCnt <= 4'd0;
            dwellCnt <= 4'd0;
        end
        else
        begin
            state <= nextState;
            // the round counter is shared by walking and sniffing
            if (state == Walk4 || state == Sniff2)
                roundCnt <= roundDone ? 4'd0 : roundCnt + 4'd1;
            if (state == Surprised || state == Jump1 || state == Jump2)
                dwellCnt <= dwellDone ? 4'd0 : dwellCnt + 4'd1;
        end
    end

    always_comb
    begin
        case (state)
            Walk1:        frame = frameWalk1;
            Walk2:        frame = frameWalk2;
            Walk3, Walk4: frame = frameWalk3;
            Sniff1:       frame = frameSniff1;
            Sniff2:       frame = frameSniff2;
            Surprised:    frame = frameSurprised;
            Jump1:        frame = frameJump1;
            Jump2:        frame = frameJump2;
            default:      frame = frameStand;
        endcase
    end

    assign done = (state == Hold);

endmodule

//--- verilog/dogMotion.sv
`timescale 1ns/100ps

module dogMotion #(
    parameter int coordWidth = 10
) (
    input  logic                  ANIM_Clk,
    input  logic                  rst,
    input  animPkg::dogState      state,
    dogCfgIf.move                 cfg,
    output logic [coordWidth-1:0] dogX,
    output logic [coordWidth-1:0] dogY
);

    import animPkg::*;

    logic [coordWidth-1:0] posX;
    logic [coordWidth-1:0] posY;

    // sums wrap at the coordinate width
    always_ff @(posedge ANIM_Clk)
    begin
        if (rst)
        begin
            posX <= cfg.startX;
            posY <= cfg.startY;
        end
        else
        begin
            case (state)
                // reloaded each resting tick so a run starts from the start point
                Rest:
                begin
                    posX <= cfg.startX;
                    posY <= cfg.startY;
                end
                Walk1, Walk2, Walk3, Walk4:
                    posX <= posX + cfg.stepSize;
                Jump1:
                begin
                    posX <= posX + cfg.jumpDx;
                    posY <= posY - cfg.jumpRise;
                end
                Jump2:
                begin
                    posX <= posX + cfg.jumpDx;
                    posY <= posY + cfg.jumpFall;
                end
                default: ;
            endcase
        end
    end

    // resting dog sits on the start point from the cycle it enters Rest
    assign dogX = (state == Rest) ? cfg.startX : posX;
    assign dogY = (state == Rest) ? cfg.startY : posY;

endmodule

//--- verilog/dogTop.sv
`timescale 1ns/100ps

module dogTop #(
    parameter int coordWidth = 10
) (
    input  logic                  ANIM_Clk,
    input  logic                  rst,
    input  logic                  go,
    input  logic                  scare,
    input  logic                  cfgWrite,
    input  logic [3:0]            cfgAddr,
    input  logic [coordWidth-1:0] cfgData,
    output logic [coordWidth-1:0] dogX,
    output logic [coordWidth-1:0] dogY,
    output logic [4:0]            frame,
    output logic                  done
);

    import animPkg::*;

    // current pose shared by sequencer and motion unit
    dogState state;

    dogCfgIf #(.coordWidth(coordWidth)) cfgBus ();

    dogConfig #(
        .coordWidth(coordWidth)
    ) config0 (
        .ANIM_Clk(ANIM_Clk),
        .rst     (rst),
        .cfgWrite(cfgWrite),
        .cfgAddr (animPkg::cfgAddr'(cfgAddr)),
        .cfgData (cfgData),
        .cfg     (cfgBus)
    );

    dogSequencer seq0 (
        .ANIM_Clk(ANIM_Clk),
        .rst     (rst),
        .go      (go),
        .scare   (scare),
        .cfg     (cfgBus),
        .state   (state),
        .frame   (frame),
        .done    (done)
    );

    dogMotion #(
        .coordWidth(coordWidth)
    ) motion0 (
        .ANIM_Clk(ANIM_Clk),
        .rst     (rst),
        .state   (state),
        .cfg     (cfgBus),
        .dogX    (dogX),
        .dogY    (dogY)
    );

endmodule

//--- bench/dogTop_props.sv
`timescale 1ns/100ps

module sequencerProps (
    input logic             ANIM_Clk,
    input logic             rst,
    input logic             go,
    input animPkg::dogState state,
    input logic             done
);

    import animPkg::*;

    // assertion failures seen so far
    int failCount = 0;

    // only the eleven pose encodings may appear
    legalState: assert property (@(posedge ANIM_Clk) disable iff (rst)
        state inside {[Rest:Hold]})
        else
        begin
            $error("sequencer state %0d is not a pose", state);
            failCount++;
        end

    // Hold is entered only once the last jump pose ends
    doneInHold: assert property (@(posedge ANIM_Clk) disable iff (rst)
        $rose(done) |-> $past(state) == Jump2)
        else
        begin
            $error("done rose without a finished jump");
            failCount++;
        end

    // the dog stays in Hold until go
    holdUntilGo: assert property (@(posedge ANIM_Clk) disable iff (rst)
        done && !go |=> done)
        else
        begin
            $error("done fell without a go strobe");
            failCount++;
        end

    // a walk set always ends in Walk1 or Sniff1
    walkNotSniff2: assert property (@(posedge ANIM_Clk) disable iff (rst)
        state == Walk4 |=> state != Sniff2)
        else
        begin
            $error("Walk4 was followed by Sniff2");
            failCount++;
        end

    jumpOrder: assert property (@(posedge ANIM_Clk) disable iff (rst)
        state == Jump1 |=> state inside {Jump1, Jump2})
        else
        begin
            $error("Jump1 was left for a state other than Jump1 or Jump2");
            failCount++;
        end

endmodule

bind dogSequencer sequencerProps seqCheck (
    .ANIM_Clk(ANIM_Clk),
    .rst     (rst),
    .go      (go),
    .state   (state),
    .done    (done)
);

//--- bench/dogTop_tb.sv
`timescale 1ns/100ps

module dogTop_tb;

    logic       ANIM_Clk;
    logic       rst;
    logic       go;
    logic       scare;
    logic       cfgWrite;
    logic [3:0] cfgAddr;
    logic [9:0] cfgData;
    logic [9:0] dogX;
    logic [9:0] dogY;
    logic [4:0] frame;
    logic       done;

    // register image built from the writes, indexed by address
    int               cfgModel [10] = '{11, 318, 4, 4, 3, 2, 5, 8, 6, 6};
    int               errCount = 0;
    int               testCount = 0;
    bit               timedOut = 1'b0;
    int               fd;
    logic [8*200-1:0] lineBuf;
    logic [8*16-1:0]  testName;
    int               nWr;
    int               wa [3];
    int               wd [3];
    int               scareLvl;
    int               quiet;
    int               fileX;
    int               fileY;

    dogTop UUT (.*);

    initial
    begin
        ANIM_Clk = 1'b0;
        forever #5 ANIM_Clk = ~ANIM_Clk;
    end

    task automatic compareValue(input logic [8*16-1:0] tName, input string what,
                                input int expVal, input int actVal);
        assert (expVal == actVal)
        else
        begin
            $display("FAIL %0s %0s expected %0d actual %0d", tName, what, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic writeRegister(input int addr, input int data);
        @(posedge ANIM_Clk);
        cfgWrite <= 1'b1;
        cfgAddr  <= addr[3:0];
        cfgData  <= data[9:0];
        // counts keep the low nibble and never drop to zero
        if (addr >= 3 && addr <= 6)
            cfgModel[addr] = (data % 16 == 0) ? 1 : data % 16;
        else
            cfgModel[addr] = data % 1024;
    endtask

    task automatic runScenario();
        int         frames[$];
        int         sets;
        int         lastSetStart;
        int         cyc;
        int         startErrors;
        bit         finished;
        logic [9:0] expX;
        logic [9:0] expY;
        startErrors = errCount;
        for (int i = 0; i < nWr; i++)
            writeRegister(wa[i], wd[i]);
        @(posedge ANIM_Clk);
        cfgWrite <= 1'b0;
        @(negedge ANIM_Clk);
        compareValue(testName, "rest dogX", cfgModel[0], dogX);
        compareValue(testName, "rest dogY", cfgModel[1], dogY);
        repeat ($urandom % 5) @(posedge ANIM_Clk);
        // expected frame of every cycle from go up to done
        sets = scareLvl ? 1 : quiet + 1;
        frames.push_back(0);
        for (int s = 0; s < sets; s++)
        begin
            if (s == sets - 1)
                lastSetStart = frames.size();
            for (int k = 0; k < 4 * cfgModel[3]; k++)
                frames.push_back(k % 4 == 3 ? 3 : k % 4 + 1);
            for (int k = 0; k < 2 * cfgModel[4]; k++)
                frames.push_back(4 + k % 2);
        end
        for (int k = 0; k < cfgModel[5]; k++)
            frames.push_back(6);
        for (int k = 0; k < 2 * cfgModel[6]; k++)
            frames.push_back(k < cfgModel[6] ? 7 : 8);
        expX = cfgModel[0];
        expY = cfgModel[1];
        cyc = 0;
        finished = 1'b0;
        @(posedge ANIM_Clk);
        go    <= 1'b1;
        scare <= scareLvl[0];
        while (!finished && cyc <= frames.size() + 50)
        begin
            @(negedge ANIM_Clk);
            if (done)
                finished = 1'b1;
            else
            begin
                if (cyc < frames.size())
                begin
                    compareValue(testName, "frame", frames[cyc], frame);
                    compareValue(testName, "dogX", expX, dogX);
                    compareValue(testName, "dogY", expY, dogY);
                    case (frames[cyc])
                        1, 2, 3: expX = expX + cfgModel[2];
                        7:
                        begin
                            expX = expX + cfgModel[7];
                            expY = expY - cfgModel[8];
                        end
                        8:
                        begin
                            expX = expX + cfgModel[7];
                            expY = expY + cfgModel[9];
                        end
                        default: ;
                    endcase
                end
                cyc++;
                @(posedge ANIM_Clk);
                go <= 1'b0;
                // scare rises once the quiet walk sets have begun to run out
                if (!scareLvl && cyc == lastSetStart + 1)
                    scare <= 1'b1;
            end
        end
        if (!finished)
        begin
            $display("%0s: done never rose within %0d cycles", testName, frames.size() + 50);
            timedOut = 1'b1;
            errCount++;
        end
        else
        begin
            compareValue(testName, "run cycles", frames.size(), cyc);
            compareValue(testName, "model dogX", fileX, expX);
            compareValue(testName, "model dogY", fileY, expY);
            compareValue(testName, "final dogX", fileX, dogX);
            compareValue(testName, "final dogY", fileY, dogY);
            // go in Hold brings the dog back to the start point
            @(posedge ANIM_Clk);
            go    <= 1'b1;
            scare <= 1'b0;
            @(posedge ANIM_Clk);
            go <= 1'b0;
            @(negedge ANIM_Clk);
            compareValue(testName, "return frame", 0, frame);
            compareValue(testName, "return done", 0, done);
            compareValue(testName, "return dogX", cfgModel[0], dogX);
            compareValue(testName, "return dogY", cfgModel[1], dogY);
        end
        testCount++;
        if (errCount == startErrors)
            $display("%0s: ok", testName);
        else
            $display("%0s: %0d errors", testName, errCount - startErrors);
    endtask

    initial
    begin
        int got;
        void'($urandom(78672));
        rst      = 1'b1;
        go       = 1'b0;
        scare    = 1'b0;
        cfgWrite = 1'b0;
        cfgAddr  = 4'd0;
        cfgData  = 10'd0;
        repeat (5) @(posedge ANIM_Clk);
        rst <= 1'b0;
        @(negedge ANIM_Clk);
        testName = "resetState";
        compareValue(testName, "dogX", 11, dogX);
        compareValue(testName, "dogY", 318, dogY);
        compareValue(testName, "frame", 0, frame);
        compareValue(testName, "done", 0, done);
        testCount++;
        $display("resetState: %0s", errCount == 0 ? "ok" : "errors");
        fd = $fopen("bench/dog_stim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file bench/dog_stim.txt");
            errCount++;
        end
        else
        begin
            while (!$feof(fd) && !timedOut)
            begin
                if ($fgets(lineBuf, fd) != 0)
                begin
                    got = $sscanf(lineBuf, "%s %d %d %d %d %d %d %d %d %d %d %d",
                                  testName, nWr, wa[0], wd[0], wa[1], wd[1], wa[2], wd[2],
                                  scareLvl, quiet, fileX, fileY);
                    // comment and blank lines never yield all twelve fields
                    if (got == 12)
                        runScenario();
                end
            end
            $fclose(fd);
        end
        // failures of the sequencer assertions count as errors too
        errCount += UUT.seq0.seqCheck.failCount;
        $display("tests run %0d, errors %0d", testCount, errCount);
        if (errCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- src.f
verilog/animPkg.sv
verilog/dogCfgIf.sv
verilog/dogConfig.sv
verilog/dogSequencer.sv
verilog/dogMotion.sv
verilog/dogTop.sv
bench/dogTop_props.sv
bench/dogTop_tb.sv

//--- Bender.yml
package:
  name: dog_anim

sources:
  - verilog/animPkg.sv
  - verilog/dogCfgIf.sv
  - verilog/dogConfig.sv
  - verilog/dogSequencer.sv
  - verilog/dogMotion.sv
  - verilog/dogTop.sv
  - target: simulation
    files:
      - bench/dogTop_props.sv
      - bench/dogTop_tb.sv

//--- bench/dog_stim.txt
# name nWr addr0 data0 addr1 data1 addr2 data2 scare quietSets expX expY
# addr 0 startX 1 startY 2 step 3 walk 4 sniff 5 surprised 6 jumpTicks 7 jumpDx 8 rise 9 fall
defaultRun 0 0 0 0 0 0 0 1 0 155 318
configRun 3 2 3 3 2 6 3 1 0 83 318
riseRun 1 8 10 0 0 0 0 1 0 83 306
quietRun 1 4 2 0 0 0 0 0 2 131 306
moveStart 3 0 100 1 200 9 10 1 0 172 200
wrapRun 3 0 1000 2 100 3 0 1 0 424 200
